//--- files.f
+incdir+include
rtl/axil_regs_pkg.sv
rtl/reg_wr_if.sv
rtl/axil_ctrl.sv
rtl/reg_bank.sv
rtl/read_data_stage.sv
rtl/axil_regs_top.sv
verif/tb_axil_regs.sv

//--- Makefile
TOP := tb_axil_regs

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f

# Pass only when the run prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- include/axil_tb_tasks.svh
`ifndef AXIL_TB_TASKS_SVH
`define AXIL_TB_TASKS_SVH

// Uses S_AXI_* signals, addr_width and int errors of the including module
localparam int tb_timeout = 100;  // Cycles per wait loop

task automatic axi_write(input logic [addr_width-1:0] addr,
                         input axil_regs_pkg::axi_word_u data,
                         input axil_regs_pkg::axi_strb_t strb,
                         output axil_regs_pkg::axi_resp_t resp);
  int cycles;
  cycles = 0;
  S_AXI_AWADDR  <= addr;
  S_AXI_AWVALID <= 1'b1;
  S_AXI_WDATA   <= data.word;
  S_AXI_WSTRB   <= strb;
  S_AXI_WVALID  <= 1'b1;
  S_AXI_BREADY  <= 1'b1;
  do begin
    @(posedge S_AXI_ACLK);
    cycles++;
  end while (!(S_AXI_AWREADY && S_AXI_WREADY) && cycles < tb_timeout);
  if (!(S_AXI_AWREADY && S_AXI_WREADY)) begin
    $display("Timeout waiting on AW/W channel at %0t", $time);
    errors++;
  end
  S_AXI_AWVALID <= 1'b0;
  S_AXI_WVALID  <= 1'b0;
  cycles = 0;
  do begin
    @(posedge S_AXI_ACLK);
    cycles++;
  end while (!S_AXI_BVALID && cycles < tb_timeout);
  if (!S_AXI_BVALID) begin
    $display("Timeout waiting on B channel at %0t", $time);
    errors++;
  end
  resp = S_AXI_BRESP;
endtask

task automatic axi_read(input logic [addr_width-1:0] addr,
                        output axil_regs_pkg::axi_word_u data,
                        output axil_regs_pkg::axi_resp_t resp);
  int cycles;
  cycles = 0;
  S_AXI_ARADDR  <= addr;
  S_AXI_ARVALID <= 1'b1;
  S_AXI_RREADY  <= 1'b1;
  do begin
    @(posedge S_AXI_ACLK);
    cycles++;
  end while (!S_AXI_ARREADY && cycles < tb_timeout);
  if (!S_AXI_ARREADY) begin
    $display("Timeout waiting on AR channel at %0t", $time);
    errors++;
  end
  S_AXI_ARVALID <= 1'b0;
  cycles = 0;
  do begin
    @(posedge S_AXI_ACLK);
    cycles++;
  end while (!S_AXI_RVALID && cycles < tb_timeout);
  if (!S_AXI_RVALID) begin
    $display("Timeout waiting on R channel at %0t", $time);
    errors++;
  end
  data = S_AXI_RDATA;
  resp = S_AXI_RRESP;
endtask

task automatic check_word(input axil_regs_pkg::axi_word_u got,
                          input axil_regs_pkg::axi_word_u exp,
                          input string msg);
  if (got.word !== exp.word) begin
    $display("[FAIL] %0t %s: got %h, expected %h", $time, msg, got.word, exp.word);
    errors++;
  end
endtask

task automatic check_resp(input axil_regs_pkg::axi_resp_t got,
                          input axil_regs_pkg::axi_resp_t exp,
                          input string msg);
  if (got !== exp) begin
    $display("[FAIL] %0t %s: resp %b, expected %b", $time, msg, got, exp);
    errors++;
  end
endtask

`endif

//--- verif/tb_axil_regs.sv
`timescale 1ns/1ps

module tb_axil_regs;

  localparam int addr_width = 7;
  localparam int n_regs     = 2 ** (addr_width - axil_regs_pkg::word_lsb);

  logic                                 S_AXI_ACLK;
  logic                                 S_AXI_ARESETN;
  logic [addr_width-1:0]                S_AXI_AWADDR;
  logic [2:0]                           S_AXI_AWPROT;
  logic                                 S_AXI_AWVALID;
  logic                                 S_AXI_AWREADY;
  logic [axil_regs_pkg::data_width-1:0] S_AXI_WDATA;
  logic [axil_regs_pkg::strb_width-1:0] S_AXI_WSTRB;
  logic                                 S_AXI_WVALID;
  logic                                 S_AXI_WREADY;
  logic [1:0]                           S_AXI_BRESP;
  logic                                 S_AXI_BVALID;
  logic                                 S_AXI_BREADY;
  logic [addr_width-1:0]                S_AXI_ARADDR;
  logic [2:0]                           S_AXI_ARPROT;
  logic                                 S_AXI_ARVALID;
  logic                                 S_AXI_ARREADY;
  logic [axil_regs_pkg::data_width-1:0] S_AXI_RDATA;
  logic [1:0]                           S_AXI_RRESP;
  logic                                 S_AXI_RVALID;
  logic                                 S_AXI_RREADY;

  int errors;
  int errors_at_start;
  int tests_run;
  int tests_failed;

  axil_regs_pkg::axi_word_u model [n_regs];  // Expected register contents

  typedef enum int {ch_aw_w, ch_b, ch_ar, ch_r} chan_t;

  `include "axil_tb_tasks.svh"

  axil_regs_top #(
    .addr_width (addr_width)
  ) uut (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWPROT  (S_AXI_AWPROT),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WSTRB   (S_AXI_WSTRB),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .S_AXI_ARPROT  (S_AXI_ARPROT),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY)
  );

  always #2 S_AXI_ACLK = ~S_AXI_ACLK;

  // ============================================================
  // Helpers
  // ============================================================

  function automatic logic [addr_width-1:0] word_addr(input int idx, input int offset);
    return addr_width'((idx << axil_regs_pkg::word_lsb) + offset);
  endfunction

  // Strobe rule applied as a bit mask over the whole word
  task automatic update_model(input int idx, input axil_regs_pkg::axi_word_u data,
                              input axil_regs_pkg::axi_strb_t strb);
    logic [axil_regs_pkg::data_width-1:0] mask;
    for (int b = 0; b < axil_regs_pkg::strb_width; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    model[idx].word = (model[idx].word & ~mask) | (data.word & mask);
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %b, expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic wait_channel(input chan_t chan);
    int   cycles;
    logic seen;
    cycles = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cycles++;
      case (chan)
        ch_aw_w: seen = S_AXI_AWREADY && S_AXI_WREADY;
        ch_b:    seen = S_AXI_BVALID;
        ch_ar:   seen = S_AXI_ARREADY;
        default: seen = S_AXI_RVALID;
      endcase
    end while (!seen && cycles < tb_timeout);
    if (!seen) begin
      $display("Timeout waiting on the %s channel at %0t", chan.name(), $time);
      errors++;
    end
  endtask

  task automatic write_and_track(input int idx, input int offset,
                                 input axil_regs_pkg::axi_word_u data,
                                 input axil_regs_pkg::axi_strb_t strb);
    axil_regs_pkg::axi_resp_t resp;
    axi_write(word_addr(idx, offset), data, strb, resp);
    check_resp(resp, axil_regs_pkg::resp_okay, $sformatf("BRESP reg %0d", idx));
    update_model(idx, data, strb);
  endtask

  task automatic read_and_compare(input int idx, input int offset);
    axil_regs_pkg::axi_word_u got;
    axil_regs_pkg::axi_resp_t resp;
    axi_read(word_addr(idx, offset), got, resp);
    check_word(got, model[idx], $sformatf("RDATA reg %0d", idx));
    check_resp(resp, axil_regs_pkg::resp_okay, $sformatf("RRESP reg %0d", idx));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d mismatches", tests_run, name,
               errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    int idx_a;
    int idx_b;
    int stall;
    axil_regs_pkg::axi_word_u wdat;
    axil_regs_pkg::axi_word_u held;
    axil_regs_pkg::axi_word_u now_word;
    axil_regs_pkg::axi_strb_t strb;

    void'($urandom(80286));
    errors = 0;
    errors_at_start = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int i = 0; i < n_regs; i++) begin
      model[i].word = '0;
    end

    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWPROT  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARPROT  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    repeat (2) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;

    check_flag(S_AXI_AWREADY, 1'b0, "AWREADY after reset");
    check_flag(S_AXI_WREADY, 1'b0, "WREADY after reset");
    check_flag(S_AXI_BVALID, 1'b0, "BVALID after reset");
    check_flag(S_AXI_ARREADY, 1'b0, "ARREADY after reset");
    check_flag(S_AXI_RVALID, 1'b0, "RVALID after reset");
    for (int i = 0; i < n_regs; i++) begin
      read_and_compare(i, 0);
    end
    end_test("reset values");

    for (int n = 0; n < 40; n++) begin
      wdat.word = $urandom;
      write_and_track($urandom_range(0, n_regs - 1), 0, wdat, 4'hf);
    end
    for (int i = 0; i < n_regs; i++) begin
      read_and_compare(i, 0);
    end
    end_test("full strobe writes");

    for (int n = 0; n < 48; n++) begin
      wdat.word = $urandom;
      strb = 4'($urandom_range(0, 15));
      write_and_track($urandom_range(0, n_regs - 1), 0, wdat, strb);
    end
    for (int i = 0; i < n_regs; i++) begin
      read_and_compare(i, 0);
    end
    end_test("partial strobes");

    for (int n = 0; n < 30; n++) begin
      idx_a = $urandom_range(0, n_regs - 1);
      wdat.word = $urandom;
      strb = 4'($urandom_range(1, 15));
      write_and_track(idx_a, $urandom_range(0, 3), wdat, strb);
      read_and_compare(idx_a, $urandom_range(0, 3));
    end
    end_test("low address bits ignored");

    // Read stall with RREADY low
    idx_a = $urandom_range(0, n_regs - 1);
    idx_b = (idx_a + 1 + $urandom_range(0, n_regs - 2)) % n_regs;
    wdat.word = $urandom;
    write_and_track(idx_a, 0, wdat, 4'hf);
    wdat.word = $urandom;
    write_and_track(idx_b, 0, wdat, 4'hf);
    S_AXI_RREADY  <= 1'b0;
    S_AXI_ARADDR  <= word_addr(idx_a, 0);
    S_AXI_ARVALID <= 1'b1;
    wait_channel(ch_ar);
    S_AXI_ARVALID <= 1'b0;
    wait_channel(ch_r);
    held = S_AXI_RDATA;
    check_word(held, model[idx_a], "first read under stall");
    S_AXI_ARADDR  <= word_addr(idx_b, 0);
    S_AXI_ARVALID <= 1'b1;
    stall = $urandom_range(3, 10);
    repeat (stall) begin
      @(posedge S_AXI_ACLK);
      now_word = S_AXI_RDATA;
      check_flag(S_AXI_RVALID, 1'b1, "RVALID while RREADY low");
      check_flag(S_AXI_ARREADY, 1'b0, "ARREADY while RREADY low");
      check_word(now_word, held, "RDATA while RREADY low");
    end
    S_AXI_RREADY <= 1'b1;
    wait_channel(ch_ar);
    S_AXI_ARVALID <= 1'b0;
    wait_channel(ch_r);
    now_word = S_AXI_RDATA;
    check_word(now_word, model[idx_b], "second read after stall");
    end_test("read back-pressure");

    // Write stall with BREADY low
    idx_a = $urandom_range(0, n_regs - 1);
    idx_b = (idx_a + 1 + $urandom_range(0, n_regs - 2)) % n_regs;
    wdat.word = $urandom;
    S_AXI_BREADY  <= 1'b0;
    S_AXI_AWADDR  <= word_addr(idx_a, 0);
    S_AXI_WDATA   <= wdat.word;
    S_AXI_WSTRB   <= 4'hf;
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WVALID  <= 1'b1;
    wait_channel(ch_aw_w);
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WVALID  <= 1'b0;
    update_model(idx_a, wdat, 4'hf);
    wait_channel(ch_b);
    check_resp(S_AXI_BRESP, axil_regs_pkg::resp_okay, "BRESP under stall");
    wdat.word = $urandom;
    strb = 4'($urandom_range(1, 15));
    S_AXI_AWADDR  <= word_addr(idx_b, 0);
    S_AXI_WDATA   <= wdat.word;
    S_AXI_WSTRB   <= strb;
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WVALID  <= 1'b1;
    stall = $urandom_range(3, 10);
    repeat (stall) begin
      @(posedge S_AXI_ACLK);
      check_flag(S_AXI_BVALID, 1'b1, "BVALID while BREADY low");
      check_flag(S_AXI_AWREADY, 1'b0, "AWREADY while BREADY low");
      check_flag(S_AXI_WREADY, 1'b0, "WREADY while BREADY low");
    end
    S_AXI_BREADY <= 1'b1;
    wait_channel(ch_aw_w);
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WVALID  <= 1'b0;
    update_model(idx_b, wdat, strb);
    wait_channel(ch_b);
    check_resp(S_AXI_BRESP, axil_regs_pkg::resp_okay, "BRESP after stall");
    read_and_compare(idx_a, 0);
    read_and_compare(idx_b, 0);
    end_test("write back-pressure");

    $display("Tests run %0d, failed %0d, total mismatches %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- rtl/axil_regs_top.sv
`timescale 1ns/1ps

module axil_regs_top #(
  parameter int addr_width = 7,
  localparam int idx_width = addr_width - axil_regs_pkg::word_lsb,
  localparam int n_regs    = 2 ** idx_width
) (
  input  logic                                 S_AXI_ACLK,
  input  logic                                 S_AXI_ARESETN,

  input  logic [addr_width-1:0]                S_AXI_AWADDR,
  input  logic [2:0]                           S_AXI_AWPROT,
  input  logic                                 S_AXI_AWVALID,
  output logic                                 S_AXI_AWREADY,

  input  logic [axil_regs_pkg::data_width-1:0] S_AXI_WDATA,
  input  logic [axil_regs_pkg::strb_width-1:0] S_AXI_WSTRB,
  input  logic                                 S_AXI_WVALID,
  output logic                                 S_AXI_WREADY,

  output logic [1:0]                           S_AXI_BRESP,
  output logic                                 S_AXI_BVALID,
  input  logic                                 S_AXI_BREADY,

  input  logic [addr_width-1:0]                S_AXI_ARADDR,
  input  logic [2:0]                           S_AXI_ARPROT,
  input  logic                                 S_AXI_ARVALID,
  output logic                                 S_AXI_ARREADY,

  output logic [axil_regs_pkg::data_width-1:0] S_AXI_RDATA,
  output logic [1:0]                           S_AXI_RRESP,
  output logic                                 S_AXI_RVALID,
  input  logic                                 S_AXI_RREADY
);

  // ============================================================
  // Internal connections
  // ============================================================

  reg_wr_if #(.addr_width(addr_width)) wr_bus ();

  logic                      rd_en;
  logic [idx_width-1:0]      rd_index;
  axil_regs_pkg::axi_word_u  regs [n_regs];

  axil_ctrl #(
    .addr_width (addr_width)
  ) u_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .rd_en         (rd_en),
    .rd_index      (rd_index),
    .wr            (wr_bus.ctrl)
  );

  reg_bank #(
    .addr_width (addr_width)
  ) u_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr            (wr_bus.bank),
    .regs          (regs)
  );

  // RDATA comes straight from the hold register
  read_data_stage #(
    .addr_width (addr_width)
  ) u_rd_stage (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .rd_en         (rd_en),
    .rd_index      (rd_index),
    .regs          (regs),
    .rdata         (S_AXI_RDATA)
  );

endmodule

//--- rtl/read_data_stage.sv
`timescale 1ns/1ps

module read_data_stage #(
  parameter int addr_width = 7,
  localparam int idx_width = addr_width - axil_regs_pkg::word_lsb,
  localparam int n_regs    = 2 ** idx_width
) (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic                      rd_en,
  input  logic [idx_width-1:0]      rd_index,
  input  axil_regs_pkg::axi_word_u  regs [n_regs],
  output axil_regs_pkg::axi_word_u  rdata
);

  axil_regs_pkg::axi_word_u sel_word;

  assign sel_word = regs[rd_index];  // Word picked by the read index

  // Held until the next accepted read, stable under RREADY stall
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rdata <= '0;
    end else if (rd_en) begin
      rdata <= sel_word;
    end
  end

endmodule

//--- rtl/reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
  parameter int addr_width = 7,
  localparam int idx_width = addr_width - axil_regs_pkg::word_lsb,
  localparam int n_regs    = 2 ** idx_width
) (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  reg_wr_if.bank                    wr,
  output axil_regs_pkg::axi_word_u  regs [n_regs]
);

  // ============================================================
  // Register storage
  // ============================================================

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < n_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en) begin
      // Lanes with a clear strobe bit keep their value
      for (int lane = 0; lane < axil_regs_pkg::strb_width; lane++) begin
        if (wr.strb[lane]) begin
          regs[wr.index].lanes[lane] <= wr.data.lanes[lane];
        end
      end
    end
  end

endmodule

//--- rtl/axil_ctrl.sv
`timescale 1ns/1ps

module axil_ctrl #(
  parameter int addr_width = 7,
  localparam int idx_width = addr_width - axil_regs_pkg::word_lsb
) (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,

  // Write address and data
  input  logic [addr_width-1:0]     awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  axil_regs_pkg::axi_word_u  wdata,
  input  axil_regs_pkg::axi_strb_t  wstrb,
  input  logic                      wvalid,
  output logic                      wready,

  // Write response
  output axil_regs_pkg::axi_resp_t  bresp,
  output logic                      bvalid,
  input  logic                      bready,

  // Read address
  input  logic [addr_width-1:0]     araddr,
  input  logic                      arvalid,
  output logic                      arready,

  // Read response
  output axil_regs_pkg::axi_resp_t  rresp,
  output logic                      rvalid,
  input  logic                      rready,

  // Read request to the data stage
  output logic                      rd_en,
  output logic [idx_width-1:0]      rd_index,

  reg_wr_if.ctrl                    wr
);

  logic                  wr_ready;    // Drives both AWREADY and WREADY
  logic [idx_width-1:0]  wr_index_q;
  logic [idx_width-1:0]  rd_index_q;
  logic                  wr_req;
  logic                  wr_hs;
  logic                  rd_req;
  logic                  rd_hs;
  logic                  b_free;
  logic                  r_free;

  // A new request waits until the previous response can leave
  assign b_free = !bvalid || bready;
  assign r_free = !rvalid || rready;

  assign wr_req = !wr_ready && awvalid && wvalid;  // Address and data together only
  assign wr_hs  = wr_ready && awvalid && wvalid;

  assign rd_req = !arready && arvalid;
  assign rd_hs  = arready && arvalid;

  // ============================================================
  // Write channel
  // ============================================================

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ready <= 1'b0;
    end else begin
      wr_ready <= wr_req && b_free;  // One-cycle pulse
    end
  end

  // Address is stable while AWVALID is held, so capture it early
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_req) begin
      wr_index_q <= awaddr[addr_width-1:axil_regs_pkg::word_lsb];
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      bvalid <= 1'b0;
    end else if (wr_hs) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  assign awready = wr_ready;
  assign wready  = wr_ready;
  assign bresp   = axil_regs_pkg::resp_okay;

  // Bank writes on the handshake edge
  assign wr.en    = wr_hs;
  assign wr.index = wr_index_q;
  assign wr.data  = wdata;
  assign wr.strb  = wstrb;

  // ============================================================
  // Read channel
  // ============================================================

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready <= 1'b0;
    end else begin
      arready <= rd_req && r_free;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_req && r_free) begin
      rd_index_q <= araddr[addr_width-1:axil_regs_pkg::word_lsb];
    end
  end

  // RVALID rises with the loaded data
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rvalid <= 1'b0;
    end else if (rd_hs) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  assign rresp    = axil_regs_pkg::resp_okay;
  assign rd_en    = rd_hs;
  assign rd_index = rd_index_q;

endmodule

//--- rtl/reg_wr_if.sv
`timescale 1ns/1ps

interface reg_wr_if #(
  parameter int addr_width = 7,
  localparam int idx_width = addr_width - axil_regs_pkg::word_lsb
);

  logic                      en;     // Single-cycle write strobe
  logic [idx_width-1:0]      index;  // Word index
  axil_regs_pkg::axi_word_u  data;
  axil_regs_pkg::axi_strb_t  strb;

  modport ctrl (
    output en,
    output index,
    output data,
    output strb
  );

  modport bank (
    input en,
    input index,
    input data,
    input strb
  );

endinterface

//--- rtl/axil_regs_pkg.sv
package axil_regs_pkg;

  // ============================================================
  // Bus geometry
  // ============================================================
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;  // One strobe bit per byte lane
  localparam int word_lsb   = 2;               // Byte offset bits inside a word

  // ============================================================
  // Shared types
  // ============================================================
  typedef logic [7:0] byte_t;

  // Whole word for storage and read-out, lanes for strobe merging
  typedef union packed {
    logic [data_width-1:0]   word;
    byte_t [strb_width-1:0]  lanes;
  } axi_word_u;

  typedef logic [strb_width-1:0] axi_strb_t;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t resp_okay = 2'b00;

endpackage
